/* hsk_pkg.sv */
package hsk_pkg;

    ////////////////////////////////////////
    // sizes and limits
    ////////////////////////////////////////

    // one data beat on the udp side carries eight bytes
    localparam int qword_bytes = 8;

    // lane index width within one qword
    localparam int lane_bits = $clog2(qword_bytes);

    // the data fifo holds this many qwords
    localparam int data_depth = 512;

    // a datagram longer than this is never stored, since the count is 9 bits
    localparam int max_qwords = 511;

    // only a handful of datagrams can wait for the host at once
    localparam int count_depth = 4;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // fill level, wide enough to hold data_depth itself
    typedef logic [9:0] level_t;

    typedef logic [63:0] qword_t;

    // number of qwords stored for one datagram
    typedef logic [8:0] count_t;

    typedef logic [lane_bits-1:0] lane_t;

    // udp header as handed over by the stack
    // length is the datagram length plus 8, in bytes, so dropping the
    // low three bits gives a qword figure that never undercounts the beats
    typedef struct packed {
        logic [31:0] ip;
        logic [15:0] port;
        logic [15:0] length;
    } udp_hdr_t;

    // one beat of udp payload, lane 0 is the first byte on the wire
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
    } udp_beat_t;

    // admission states of the receive side
    typedef enum logic [1:0] {
        rx_idle,
        rx_store,
        rx_complete,
        rx_dump
    } rx_state_t;

endpackage

/* hsk_fifo.sv */
`timescale 1ns/1ps

module hsk_fifo #(
    parameter type item_t = hsk_pkg::count_t,
    parameter int  depth  = hsk_pkg::count_depth
) (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            wr_en,
    input  item_t           wr_data,
    output logic            full,
    output hsk_pkg::level_t level,
    input  logic            rd_en,
    output logic            valid,
    output item_t           rd_data
);

    typedef logic [$clog2(depth)-1:0] ptr_t;

    // storage has no reset, only the pointers and level do
    item_t mem [depth];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic push;
    logic pop;

    assign full  = (level == hsk_pkg::level_t'(depth));
    assign valid = (level != '0);

    // show-ahead: the head entry is always on rd_data
    assign rd_data = mem[rd_ptr];

    // writes into a full fifo and reads from an empty one are ignored
    assign push = wr_en && !full;
    assign pop  = rd_en && valid;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            // pointers wrap at depth, which need not be a power of two
            if (push) begin
                if (wr_ptr == ptr_t'(depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == ptr_t'(depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            // level moves only when exactly one side is active
            case ({push, pop})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

/* udp_hsk_rx.sv */
`timescale 1ns/1ps

module udp_hsk_rx (
    input  logic               aclk,
    input  logic               aresetn,
    input  hsk_pkg::udp_hdr_t  hdr,
    input  logic               hdr_valid,
    output logic               hdr_ready,
    input  hsk_pkg::udp_beat_t beat,
    input  logic               beat_valid,
    output logic               beat_ready,
    input  hsk_pkg::level_t    data_level,
    input  logic               count_full,
    output logic               data_wr_en,
    output hsk_pkg::qword_t    data_wr,
    output logic               count_wr_en,
    output hsk_pkg::count_t    count_wr
);

    hsk_pkg::rx_state_t state;
    hsk_pkg::count_t    qword_cnt;

    logic        hdr_fire;
    logic        beat_fire;
    logic [12:0] length_qw;
    logic [12:0] free_qw;
    logic        too_long;
    logic        no_room;

    ////////////////////////////////////////
    // admission check
    ////////////////////////////////////////

    // headers are only taken while nothing else is in flight
    assign hdr_ready = (state == hsk_pkg::rx_idle);
    assign hdr_fire  = hdr_valid && hdr_ready;

    // length is datagram bytes plus 8, so a plain shift rounds up safely
    assign length_qw = hdr.length[15:3];

    // free entries in the data fifo right now
    // any earlier datagram has already landed by the time we are back in idle
    assign free_qw = 13'(hsk_pkg::data_depth) - 13'(data_level);

    assign too_long = (length_qw > 13'(hsk_pkg::max_qwords));
    assign no_room  = (length_qw > free_qw);

    ////////////////////////////////////////
    // beat path
    ////////////////////////////////////////

    // room was checked up front, so beats are never held off once admitted
    assign beat_ready = (state == hsk_pkg::rx_store) || (state == hsk_pkg::rx_dump);
    assign beat_fire  = beat_valid && beat_ready;

    // lanes without keep are stored as zero bytes so the host reads padding as 0
    always_comb begin
        for (int i = 0; i < hsk_pkg::qword_bytes; i++) begin
            data_wr[8*i +: 8] = beat.keep[i] ? beat.data[8*i +: 8] : 8'h00;
        end
    end

    assign data_wr_en = beat_fire && (state == hsk_pkg::rx_store);

    // the count goes out in the single complete cycle after last
    assign count_wr_en = (state == hsk_pkg::rx_complete);
    assign count_wr    = qword_cnt;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= hsk_pkg::rx_idle;
            qword_cnt <= '0;
        end else begin
            // qword counter restarts for every datagram
            if (state == hsk_pkg::rx_idle) begin
                qword_cnt <= '0;
            end else if (data_wr_en) begin
                qword_cnt <= qword_cnt + 1'b1;
            end

            case (state)
                hsk_pkg::rx_idle: begin
                    if (hdr_fire) begin
                        // a full count fifo would lose the count, so dump as well
                        if (too_long || no_room || count_full) begin
                            state <= hsk_pkg::rx_dump;
                        end else begin
                            state <= hsk_pkg::rx_store;
                        end
                    end
                end
                hsk_pkg::rx_store: begin
                    if (beat_fire && beat.last) begin
                        state <= hsk_pkg::rx_complete;
                    end
                end
                hsk_pkg::rx_complete: begin
                    state <= hsk_pkg::rx_idle;
                end
                hsk_pkg::rx_dump: begin
                    // beats are swallowed until the end of the datagram
                    if (beat_fire && beat.last) begin
                        state <= hsk_pkg::rx_idle;
                    end
                end
                default: begin
                    state <= hsk_pkg::rx_idle;
                end
            endcase
        end
    end

endmodule

/* hsk_spi_readout.sv */
`timescale 1ns/1ps

module hsk_spi_readout (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            cs_b,
    input  logic            sclk,
    output logic            miso,
    output logic            irq,
    input  logic            count_valid,
    input  hsk_pkg::count_t count,
    output logic            count_rd,
    input  logic            data_valid,
    input  hsk_pkg::qword_t data,
    output logic            data_rd
);

    ////////////////////////////////////////
    // serial input sampling
    ////////////////////////////////////////

    // bits 0 and 1 synchronize, bit 2 is the previous synchronized level
    logic [2:0] cs_sr;
    logic [2:0] sclk_sr;
    logic       cs_fall;
    logic       cs_rise;
    logic       sclk_rise;

    assign cs_fall   = cs_sr[2] && !cs_sr[1];
    assign cs_rise   = !cs_sr[2] && cs_sr[1];
    assign sclk_rise = !sclk_sr[2] && sclk_sr[1];

    ////////////////////////////////////////
    // readout state
    ////////////////////////////////////////

    logic            reading;
    logic            draining;
    logic            reload;
    logic [2:0]      bit_cnt;
    hsk_pkg::lane_t  lane;
    hsk_pkg::lane_t  next_lane;
    hsk_pkg::count_t qw_idx;
    logic [7:0]      hold;
    logic            last_lane;
    logic            last_qword;
    logic            byte_done;

    assign next_lane  = lane + 1'b1;
    assign last_lane  = (lane == hsk_pkg::lane_t'(hsk_pkg::qword_bytes - 1));
    assign last_qword = (qw_idx == count - 1'b1);

    // the eighth rising edge of a byte, when nothing with higher priority is pending
    assign byte_done = reading && !cs_rise && !reload && sclk_rise && (bit_cnt == 3'd7);

    // the head qword is done after its last lane, or at once while draining
    assign data_rd  = (byte_done && last_lane) || draining;
    // and the count goes with the final qword of the datagram
    assign count_rd = data_rd && last_qword;

    // msb first out of the holding register, zero whenever idle
    assign miso = hold[7];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cs_sr    <= '1;
            sclk_sr  <= '0;
            reading  <= 1'b0;
            draining <= 1'b0;
            reload   <= 1'b0;
            bit_cnt  <= '0;
            lane     <= '0;
            qw_idx   <= '0;
            hold     <= '0;
            irq      <= 1'b0;
        end else begin
            cs_sr   <= {cs_sr[1:0], cs_b};
            sclk_sr <= {sclk_sr[1:0], sclk};

            // irq drops for at least one cycle after each datagram leaves
            // and comes back if another count is already waiting
            irq <= count_valid && !count_rd;

            if (draining) begin
                // one qword per cycle until the whole datagram is gone
                qw_idx <= qw_idx + 1'b1;
                if (last_qword) begin
                    draining <= 1'b0;
                end
            end else if (reading && cs_rise) begin
                // host gave up early, throw away what is left of this datagram
                reading  <= 1'b0;
                draining <= 1'b1;
                reload   <= 1'b0;
                hold     <= '0;
            end else if (reading) begin
                if (reload) begin
                    // the new head qword shows up the cycle after the pop
                    hold   <= data[7:0];
                    reload <= 1'b0;
                end else if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt != 3'd7) begin
                        hold <= {hold[6:0], 1'b0};
                    end else if (!last_lane) begin
                        lane <= next_lane;
                        hold <= data[8*next_lane +: 8];
                    end else if (last_qword) begin
                        // that was byte count*8, nothing more to send
                        reading <= 1'b0;
                        hold    <= '0;
                    end else begin
                        lane   <= '0;
                        qw_idx <= qw_idx + 1'b1;
                        reload <= 1'b1;
                    end
                end
            end else if (cs_fall && count_valid && data_valid) begin
                // counts are written after their data, so data is always there
                reading <= 1'b1;
                bit_cnt <= '0;
                lane    <= '0;
                qw_idx  <= '0;
                hold    <= data[7:0];
            end
        end
    end

endmodule

/* udp_hsk_top.sv */
`timescale 1ns/1ps

module udp_hsk_top (
    input  logic               aclk,
    input  logic               aresetn,
    input  hsk_pkg::udp_hdr_t  hdr,
    input  logic               hdr_valid,
    output logic               hdr_ready,
    input  hsk_pkg::udp_beat_t beat,
    input  logic               beat_valid,
    output logic               beat_ready,
    input  logic               cs_b,
    input  logic               sclk,
    output logic               miso,
    output logic               irq
);

    ////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////

    // data fifo, udp side in and serial side out
    logic            data_wr_en;
    hsk_pkg::qword_t data_wr;
    hsk_pkg::level_t data_level;
    logic            data_rd;
    logic            data_valid;
    hsk_pkg::qword_t data_head;

    // count fifo, one entry per stored datagram
    logic            count_wr_en;
    hsk_pkg::count_t count_wr;
    logic            count_full;
    logic            count_rd;
    logic            count_valid;
    hsk_pkg::count_t count_head;

    udp_hsk_rx u_rx (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .hdr         (hdr),
        .hdr_valid   (hdr_valid),
        .hdr_ready   (hdr_ready),
        .beat        (beat),
        .beat_valid  (beat_valid),
        .beat_ready  (beat_ready),
        .data_level  (data_level),
        .count_full  (count_full),
        .data_wr_en  (data_wr_en),
        .data_wr     (data_wr),
        .count_wr_en (count_wr_en),
        .count_wr    (count_wr)
    );

    // admission keeps this one from ever filling, so full is not needed
    hsk_fifo #(
        .item_t (hsk_pkg::qword_t),
        .depth  (hsk_pkg::data_depth)
    ) u_data_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wr_en   (data_wr_en),
        .wr_data (data_wr),
        .full    (),
        .level   (data_level),
        .rd_en   (data_rd),
        .valid   (data_valid),
        .rd_data (data_head)
    );

    hsk_fifo #(
        .item_t (hsk_pkg::count_t),
        .depth  (hsk_pkg::count_depth)
    ) u_count_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wr_en   (count_wr_en),
        .wr_data (count_wr),
        .full    (count_full),
        .level   (),
        .rd_en   (count_rd),
        .valid   (count_valid),
        .rd_data (count_head)
    );

    hsk_spi_readout u_readout (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .cs_b        (cs_b),
        .sclk        (sclk),
        .miso        (miso),
        .irq         (irq),
        .count_valid (count_valid),
        .count       (count_head),
        .count_rd    (count_rd),
        .data_valid  (data_valid),
        .data        (data_head),
        .data_rd     (data_rd)
    );

endmodule

/* udp_hsk_asserts.sv */
`timescale 1ns/1ps

module udp_hsk_asserts (
    input logic               aclk,
    input logic               aresetn,
    input hsk_pkg::rx_state_t rx_state,
    input logic               hdr_valid,
    input logic               hdr_ready,
    input hsk_pkg::udp_beat_t beat,
    input logic               beat_valid,
    input logic               beat_ready,
    input logic               cs_b,
    input logic               miso
);

    // number of assertion failures so far, read by the testbench at the end
    int fail_count;

    initial fail_count = 0;

    ////////////////////////////////////////
    // serial port
    ////////////////////////////////////////

    // cs_b goes through two synchronizer stages and an edge register,
    // so miso is only required to be quiet once cs_b has been high a while
    property miso_quiet_p;
        @(posedge aclk) disable iff (!aresetn)
        (cs_b && $past(cs_b, 1) && $past(cs_b, 2) && $past(cs_b, 3) && $past(cs_b, 4))
            |-> !miso;
    endproperty

    ////////////////////////////////////////
    // admission handshake
    ////////////////////////////////////////

    // the last beat ends the datagram, the receiver is then completing or idle
    // and takes no further beat until the next header
    property idle_no_beat_p;
        @(posedge aclk) disable iff (!aresetn)
        (beat_valid && beat_ready && beat.last) |=> !beat_ready;
    endproperty

    // an accepted header takes the receiver out of idle and closes hdr_ready
    property hdr_only_idle_p;
        @(posedge aclk) disable iff (!aresetn)
        (hdr_valid && hdr_ready) |=> (rx_state != hsk_pkg::rx_idle) && !hdr_ready;
    endproperty

    assert property (miso_quiet_p) else begin
        $error("miso high while cs_b is high");
        fail_count++;
    end

    assert property (idle_no_beat_p) else begin
        $error("beat_ready high after the last beat of a datagram");
        fail_count++;
    end

    assert property (hdr_only_idle_p) else begin
        $error("hdr_ready high right after a header was taken");
        fail_count++;
    end

endmodule

bind udp_hsk_top udp_hsk_asserts u_asserts (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .rx_state   (u_rx.state),
    .hdr_valid  (hdr_valid),
    .hdr_ready  (hdr_ready),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .cs_b       (cs_b),
    .miso       (miso)
);

/* tb_udp_hsk.sv */
`timescale 1ns/1ps

module tb_udp_hsk;

    ////////////////////////////////////////
    // run length
    ////////////////////////////////////////

    // aclk cycles per sclk half period on the host side
    localparam int half_sclk = 8;
    localparam int byte_cycles = 2 * half_sclk * 8;
    // bytes clocked out over all tests, most of them in the data fifo fill test
    localparam int read_bytes_est = 3500;
    // headers, beats and the idle gaps around each read
    localparam int other_cycles = 20000;
    localparam int est_cycles = read_bytes_est * byte_cycles + other_cycles;

    logic               aclk;
    logic               aresetn;
    hsk_pkg::udp_hdr_t  hdr;
    logic               hdr_valid;
    logic               hdr_ready;
    hsk_pkg::udp_beat_t beat;
    logic               beat_valid;
    logic               beat_ready;
    logic               cs_b;
    logic               sclk;
    logic               miso;
    logic               irq;

    int errors;
    int checks;

    // model of what the host should see, bytes in read order and bytes per datagram
    logic [7:0] exp_bytes[$];
    int         exp_counts[$];
    // bytes collected by the last read
    logic [7:0] got_bytes[$];

    udp_hsk_top u_udp_hsk_top (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .hdr        (hdr),
        .hdr_valid  (hdr_valid),
        .hdr_ready  (hdr_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .cs_b       (cs_b),
        .sclk       (sclk),
        .miso       (miso),
        .irq        (irq)
    );

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (irq !== level && cycles < 200) begin
            @(negedge aclk);
            cycles++;
        end
        if (irq !== level) begin
            errors++;
            $display("irq did not reach %0b within %0d cycles, time %0t", level, cycles, $time);
        end
    endtask

    ////////////////////////////////////////
    // udp side driver
    ////////////////////////////////////////

    // sends nbytes of random payload and tells whether the admission rules keep it
    task automatic send_datagram(input int nbytes, output bit stored);
        int          n_beats;
        int          len_qw;
        int          left;
        logic [7:0]  keep;
        logic [63:0] data;
        n_beats = (nbytes + 7) / 8;
        len_qw  = (nbytes + 8) / 8;
        // dropped when too long, short of free qwords or with no count slot left
        stored = !(len_qw > hsk_pkg::max_qwords ||
                   len_qw > hsk_pkg::data_depth - exp_bytes.size() / 8 ||
                   exp_counts.size() == hsk_pkg::count_depth);
        @(posedge aclk);
        #2;
        hdr.ip     = 32'hc0a8_0a01;
        hdr.port   = 16'd5005;
        hdr.length = 16'(nbytes + 8);
        hdr_valid  = 1'b1;
        do @(negedge aclk); while (hdr_ready !== 1'b1);
        @(posedge aclk);
        #2;
        hdr_valid = 1'b0;
        left = nbytes;
        for (int b = 0; b < n_beats; b++) begin
            data = {$urandom(), $urandom()};
            keep = (left >= 8) ? 8'hff : 8'((1 << left) - 1);
            beat.data  = data;
            beat.keep  = keep;
            beat.last  = (b == n_beats - 1);
            beat_valid = 1'b1;
            do @(negedge aclk); while (beat_ready !== 1'b1);
            @(posedge aclk);
            #2;
            // padding lanes come back as zero bytes
            if (stored) begin
                for (int i = 0; i < 8; i++) begin
                    exp_bytes.push_back(keep[i] ? data[8*i +: 8] : 8'h00);
                end
            end
            left = left - 8;
        end
        beat_valid = 1'b0;
        if (stored) begin
            exp_counts.push_back(n_beats * 8);
        end
    endtask

    ////////////////////////////////////////
    // host side reader
    ////////////////////////////////////////

    // clocks n bytes out of miso with cs_b low, then lets cs_b go high again
    task automatic read_bytes(input int n);
        logic [7:0] value;
        value = '0;
        got_bytes.delete();
        @(posedge aclk);
        #2;
        cs_b = 1'b0;
        repeat (half_sclk) @(posedge aclk);
        for (int i = 0; i < n; i++) begin
            for (int k = 0; k < 8; k++) begin
                #2;
                sclk = 1'b1;
                // miso still holds the current bit until the readout sees the edge
                @(negedge aclk);
                value = {value[6:0], miso};
                repeat (half_sclk) @(posedge aclk);
                #2;
                sclk = 1'b0;
                repeat (half_sclk) @(posedge aclk);
            end
            got_bytes.push_back(value);
        end
        #2;
        cs_b = 1'b1;
        // room for the readout to see cs_b rise and drain what is left
        repeat (4 * half_sclk) @(posedge aclk);
        // outputs are looked at away from the active edge
        @(negedge aclk);
    endtask

    // reads the oldest stored datagram plus one qword past its end,
    // or one qword of zeros when none is stored
    task automatic read_datagram();
        int         n;
        logic [7:0] exp;
        if (exp_counts.size() == 0) begin
            read_bytes(hsk_pkg::qword_bytes);
            foreach (got_bytes[i]) begin
                check($sformatf("miso byte %0d", i), 64'(got_bytes[i]), 64'h0);
            end
        end else begin
            n = exp_counts.pop_front();
            read_bytes(n + hsk_pkg::qword_bytes);
            for (int i = 0; i < n; i++) begin
                exp = exp_bytes.pop_front();
                check($sformatf("miso byte %0d", i), 64'(got_bytes[i]), 64'(exp));
            end
            // once count times 8 bytes are out, miso stays low until the next read
            for (int i = n; i < n + hsk_pkg::qword_bytes; i++) begin
                check($sformatf("miso byte %0d", i), 64'(got_bytes[i]), 64'h0);
            end
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic check_reset_state();
        @(negedge aclk);
        check("irq", 64'(irq), 64'h0);
        check("miso", 64'(miso), 64'h0);
        check("beat_ready", 64'(beat_ready), 64'h0);
        check("hdr_ready", 64'(hdr_ready), 64'h1);
    endtask

    // 21 bytes in three beats, the last one with keep 0x1f
    task automatic padded_datagram();
        bit stored;
        send_datagram(21, stored);
        wait_irq(1'b1);
        read_datagram();
        for (int i = 21; i < 24; i++) begin
            check($sformatf("pad byte %0d", i), 64'(got_bytes[i]), 64'h0);
        end
        check("irq", 64'(irq), 64'h0);
    endtask

    // 512 qwords is past the 511 limit although the empty data fifo has room for it,
    // beats still flow but nothing is kept
    task automatic oversize_dump();
        bit stored;
        send_datagram(4088, stored);
        repeat (10) @(negedge aclk);
        check("irq", 64'(irq), 64'h0);
        read_datagram();
        check("irq", 64'(irq), 64'h0);
        check("hdr_ready", 64'(hdr_ready), 64'h1);
    endtask

    // the fifth datagram finds all four count slots taken
    task automatic count_fifo_full();
        bit stored;
        for (int i = 0; i < 5; i++) begin
            send_datagram(8 + 6 * i, stored);
        end
        for (int i = 0; i < 4; i++) begin
            wait_irq(1'b1);
            read_datagram();
        end
        read_datagram();
        check("irq", 64'(irq), 64'h0);
    endtask

    // cs_b rises after three bytes, the rest of that datagram is thrown away
    task automatic aborted_read();
        bit         stored;
        int         n;
        logic [7:0] exp;
        send_datagram(24, stored);
        send_datagram(16, stored);
        wait_irq(1'b1);
        read_bytes(3);
        n = exp_counts.pop_front();
        for (int i = 0; i < n; i++) begin
            exp = exp_bytes.pop_front();
            if (i < 3) begin
                check($sformatf("miso byte %0d", i), 64'(got_bytes[i]), 64'(exp));
            end
        end
        wait_irq(1'b1);
        read_datagram();
        check("irq", 64'(irq), 64'h0);
    endtask

    // 200-qword datagrams until the next one no longer fits in the data fifo
    task automatic data_fifo_full();
        bit stored;
        int sent;
        sent = 0;
        do begin
            send_datagram(1600, stored);
            sent++;
        end while (stored && sent < 8);
        while (exp_counts.size() != 0) begin
            wait_irq(1'b1);
            read_datagram();
        end
        read_datagram();
        check("irq", 64'(irq), 64'h0);
    endtask

    // watchdog, four times the estimated length of all tests
    initial begin
        repeat (est_cycles * 4) @(posedge aclk);
        $display("timeout: tests did not finish within %0d cycles", est_cycles * 4);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int afails;
        void'($urandom(65693));
        aresetn    = 1'b0;
        hdr        = '0;
        hdr_valid  = 1'b0;
        beat       = '0;
        beat_valid = 1'b0;
        cs_b       = 1'b1;
        sclk       = 1'b0;
        errors     = 0;
        checks     = 0;
        repeat (10) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        check_reset_state();
        padded_datagram();
        oversize_dump();
        count_fifo_full();
        aborted_read();
        data_fifo_full();

        afails = u_udp_hsk_top.u_asserts.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* udp_hsk_top.f */
hsk_pkg.sv
hsk_fifo.sv
udp_hsk_rx.sv
hsk_spi_readout.sv
udp_hsk_top.sv
udp_hsk_asserts.sv
tb_udp_hsk.sv

/* Makefile */
SIM        := verilator
TOP        := tb_udp_hsk
FILELIST   := udp_hsk_top.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
